//--- wb_vectors.txt
// kind_we_rd_size_sign_offset_err_data_expected, kind 0 alu 1 load 2 copro 3 kill 4 halt f end
// size 0 byte 1 half 2 word, err is bus_err_i for loads and xif_result_exc_i for copro
0_1_01_0_0_0_0_12345678_12345678
0_1_00_0_0_0_0_deadbeef_00000000
1_1_02_0_1_0_0_9c3e81f5_fffffff5
1_1_03_0_0_0_0_9c3e81f5_000000f5
1_1_04_0_1_1_0_9c3e81f5_ffffff81
1_1_05_0_1_2_0_9c3e81f5_0000003e
1_1_06_0_0_3_0_9c3e81f5_0000009c
1_1_07_0_1_3_0_9c3e81f5_ffffff9c
1_1_08_1_1_0_0_9c3e81f5_ffff81f5
1_1_09_1_0_2_0_9c3e81f5_00009c3e
1_1_0a_1_1_2_0_9c3e81f5_ffff9c3e
1_1_0b_2_0_0_0_9c3e81f5_9c3e81f5
1_1_01_0_0_0_1_aaaaaaaa_12345678
2_1_0c_0_0_0_0_0badf00d_0badf00d
2_1_0c_0_0_0_1_11111111_0badf00d
3_1_01_0_0_0_0_55555555_12345678
4_1_0d_0_0_0_0_600dcafe_600dcafe
f_0_00_0_0_0_0_00000000_00000000

//--- files.f
wb_pkg.sv
lsu_pkg.sv
ex_wb_reg.sv
load_resp.sv
wb_stage.sv
regfile.sv
wb_top.sv
tb_clkgen.sv
tb_wb_top_sva.sv
tb_wb_top.sv

//--- Makefile
# Verilator build and run for the write-back testbench

VERILATOR ?= verilator
TOP       ?= tb_wb_top
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter %.sv %.v,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "ERRORS FOUND" $(LOG) || \
	   ! grep -q "NO ERRORS" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_wb_top.sv
// Testbench for the write-back end
// Reads wb_vectors.txt, drives each instruction with its bus response or
// coprocessor result, and checks the destination through read port A
`timescale 1ns/100ps
`default_nettype none

module tb_wb_top;

  localparam int MAX_VECTORS    = 64;
  localparam int TIMEOUT_CYCLES = 50;

  // Test kinds in the first vector column
  localparam logic [3:0] KIND_ALU  = 4'h0;
  localparam logic [3:0] KIND_LOAD = 4'h1;
  localparam logic [3:0] KIND_XIF  = 4'h2;
  localparam logic [3:0] KIND_KILL = 4'h3;
  localparam logic [3:0] KIND_HALT = 4'h4;
  localparam logic [3:0] KIND_END  = 4'hf;

  // Wait conditions
  localparam int COND_VALID = 0;
  localparam int COND_READY = 1;
  localparam int COND_IDLE  = 2;

  logic        clk;
  logic        arst_n_i;
  logic        ex_valid_i;
  logic        ex_rf_we_i;
  logic [4:0]  ex_rf_waddr_i;
  logic [31:0] ex_rf_wdata_i;
  logic        ex_lsu_en_i;
  logic [1:0]  ex_lsu_size_i;
  logic        ex_lsu_sign_i;
  logic [1:0]  ex_lsu_offset_i;
  logic        ex_xif_en_i;
  logic        ex_ready_o;
  logic        kill_wb_i;
  logic        halt_wb_i;
  logic        bus_rvalid_i;
  logic [31:0] bus_rdata_i;
  logic        bus_err_i;
  logic        xif_result_valid_i;
  logic [31:0] xif_result_data_i;
  logic        xif_result_exc_i;
  logic        xif_result_ready_o;
  logic        wb_valid_o;
  logic        data_stall_o;
  logic [4:0]  rd_addr_a_i;
  logic [4:0]  rd_addr_b_i;
  logic [31:0] rd_data_a_o;
  logic [31:0] rd_data_b_o;

  logic [95:0] vectors [MAX_VECTORS];
  // Expected register contents, built from the vector results
  logic [31:0] model_rf [32];
  int          seed;
  int          error_count;
  int          pass_count;
  int          fail_count;
  bit          timed_out;

  tb_clkgen u_clkgen (.clk_o(clk));

  wb_top uut (
    .clk                (clk),
    .arst_n_i           (arst_n_i),
    .ex_valid_i         (ex_valid_i),
    .ex_rf_we_i         (ex_rf_we_i),
    .ex_rf_waddr_i      (ex_rf_waddr_i),
    .ex_rf_wdata_i      (ex_rf_wdata_i),
    .ex_lsu_en_i        (ex_lsu_en_i),
    .ex_lsu_size_i      (ex_lsu_size_i),
    .ex_lsu_sign_i      (ex_lsu_sign_i),
    .ex_lsu_offset_i    (ex_lsu_offset_i),
    .ex_xif_en_i        (ex_xif_en_i),
    .ex_ready_o         (ex_ready_o),
    .kill_wb_i          (kill_wb_i),
    .halt_wb_i          (halt_wb_i),
    .bus_rvalid_i       (bus_rvalid_i),
    .bus_rdata_i        (bus_rdata_i),
    .bus_err_i          (bus_err_i),
    .xif_result_valid_i (xif_result_valid_i),
    .xif_result_data_i  (xif_result_data_i),
    .xif_result_exc_i   (xif_result_exc_i),
    .xif_result_ready_o (xif_result_ready_o),
    .wb_valid_o         (wb_valid_o),
    .data_stall_o       (data_stall_o),
    .rd_addr_a_i        (rd_addr_a_i),
    .rd_addr_b_i        (rd_addr_b_i),
    .rd_data_a_o        (rd_data_a_o),
    .rd_data_b_o        (rd_data_b_o)
  );

  // Clock, bus pulse and stage signals all meet in the top level
  bind wb_top tb_wb_top_sva u_sva (
    .clk                (clk),
    .arst_n_i           (arst_n_i),
    .wb_valid_i         (wb_valid_o),
    .data_stall_i       (data_stall_o),
    .halt_wb_i          (halt_wb_i),
    .kill_wb_i          (kill_wb_i),
    .rf_we_i            (rf_we),
    .xif_result_ready_i (xif_result_ready_o),
    .instr_valid_i      (wb_instr_valid),
    .xif_en_i           (wb_xif_en),
    .bus_rvalid_i       (bus_rvalid_i),
    .lsu_valid_i        (lsu_valid),
    .lsu_rvalid_i       (lsu_rvalid)
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic string kind_name(input logic [3:0] kind);
    case (kind)
      KIND_ALU:  return "alu";
      KIND_LOAD: return "load";
      KIND_XIF:  return "copro";
      KIND_KILL: return "kill";
      KIND_HALT: return "halt";
      default:   return "unknown";
    endcase
  endfunction

  function automatic bit condition_met(input int cond_sel);
    case (cond_sel)
      COND_VALID: return wb_valid_o;
      COND_READY: return ex_ready_o;
      default:    return ex_ready_o && !wb_valid_o && !data_stall_o;
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp_val);
    $display("** Error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp_val);
    error_count++;
  endtask

  // Polls at the falling edge, where outputs are settled
  task automatic wait_until(input int cond_sel, input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!condition_met(cond_sel) && !timed_out) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("Timeout after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
        timed_out = 1'b1;
      end else begin
        @(negedge clk);
      end
    end
  endtask

  // Register under test on port A, x0 on port B
  task automatic check_result(input logic [4:0] rd, input logic [31:0] exp_val);
    if (rd_data_a_o !== exp_val) report_mismatch("rd_data_a_o", rd_data_a_o, exp_val);
    if (rd_data_b_o !== 32'd0) report_mismatch("rd_data_b_o", rd_data_b_o, 32'd0);
    if (rd != 5'd0) model_rf[rd] = exp_val;
  endtask

  //////////////////////////////////////////////////////////////////////
  // One vector
  //////////////////////////////////////////////////////////////////////

  task automatic run_test(input logic [95:0] v, input int idx);
    logic [3:0]  kind;
    logic [4:0]  rd;
    logic [31:0] data;
    logic [31:0] exp_val;
    logic        err;
    int          delay;
    int          errors_before;
    kind          = v[95:92];
    rd            = v[84:80];
    err           = v[64];
    data          = v[63:32];
    exp_val       = v[31:0];
    errors_before = error_count;
    delay         = {$random(seed)} % 4;
    wait_until(COND_IDLE, "an idle stage");

    // Offer the instruction until the stage takes it
    @(posedge clk);
    ex_valid_i      <= 1'b1;
    ex_rf_we_i      <= v[88];
    ex_rf_waddr_i   <= rd;
    ex_rf_wdata_i   <= (kind == KIND_LOAD || kind == KIND_XIF) ? $random(seed) : data;
    ex_lsu_en_i     <= (kind == KIND_LOAD);
    ex_lsu_size_i   <= v[77:76];
    ex_lsu_sign_i   <= v[72];
    ex_lsu_offset_i <= v[69:68];
    ex_xif_en_i     <= (kind == KIND_XIF);
    rd_addr_a_i     <= rd;
    wait_until(COND_READY, "ex_ready_o");
    @(posedge clk);
    ex_valid_i <= 1'b0;

    case (kind)
      KIND_LOAD: begin
        @(negedge clk);
        if (data_stall_o !== 1'b1) report_mismatch("data_stall_o", 32'(data_stall_o), 32'd1);
        if (wb_valid_o !== 1'b0) report_mismatch("wb_valid_o", 32'(wb_valid_o), 32'd0);
        @(posedge clk);
        repeat (delay) @(posedge clk);
        bus_rvalid_i <= 1'b1;
        bus_rdata_i  <= data;
        bus_err_i    <= err;
        @(posedge clk);
        bus_rvalid_i <= 1'b0;
        bus_err_i    <= 1'b0;
        wait_until(COND_VALID, "wb_valid_o after the load response");
        @(posedge clk);
        @(negedge clk);
      end
      KIND_XIF: begin
        // Stage blocks until the result arrives
        @(negedge clk);
        if (ex_ready_o !== 1'b0) report_mismatch("ex_ready_o", 32'(ex_ready_o), 32'd0);
        if (xif_result_ready_o !== 1'b1) begin
          report_mismatch("xif_result_ready_o", 32'(xif_result_ready_o), 32'd1);
        end
        if (rd_data_a_o !== model_rf[rd]) report_mismatch("rd_data_a_o", rd_data_a_o, model_rf[rd]);
        @(posedge clk);
        repeat (delay) @(posedge clk);
        xif_result_valid_i <= 1'b1;
        xif_result_data_i  <= data;
        xif_result_exc_i   <= err;
        wait_until(COND_VALID, "wb_valid_o after the coprocessor result");
        @(posedge clk);
        xif_result_valid_i <= 1'b0;
        xif_result_exc_i   <= 1'b0;
        @(negedge clk);
      end
      KIND_KILL: begin
        kill_wb_i <= 1'b1;
        @(negedge clk);
        if (wb_valid_o !== 1'b0) report_mismatch("wb_valid_o", 32'(wb_valid_o), 32'd0);
        if (ex_ready_o !== 1'b1) report_mismatch("ex_ready_o", 32'(ex_ready_o), 32'd1);
        @(posedge clk);
        kill_wb_i <= 1'b0;
        wait_until(COND_IDLE, "the killed instruction to clear");
      end
      KIND_HALT: begin
        // Held past the edge where it would have written
        halt_wb_i <= 1'b1;
        repeat (delay + 2) begin
          @(negedge clk);
          if (wb_valid_o !== 1'b0) report_mismatch("wb_valid_o", 32'(wb_valid_o), 32'd0);
          if (ex_ready_o !== 1'b0) report_mismatch("ex_ready_o", 32'(ex_ready_o), 32'd0);
          if (rd_data_a_o !== model_rf[rd]) begin
            report_mismatch("rd_data_a_o", rd_data_a_o, model_rf[rd]);
          end
        end
        @(posedge clk);
        halt_wb_i <= 1'b0;
        wait_until(COND_VALID, "wb_valid_o after the halt");
        @(posedge clk);
        @(negedge clk);
      end
      default: begin
        wait_until(COND_VALID, "wb_valid_o for the execute result");
        @(posedge clk);
        @(negedge clk);
      end
    endcase

    check_result(rd, exp_val);
    if (error_count == errors_before && !timed_out) begin
      pass_count++;
      $display("test %0d %s x%0d: pass", idx, kind_name(kind), rd);
    end else begin
      fail_count++;
      $display("test %0d %s x%0d: fail", idx, kind_name(kind), rd);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int idx;
    arst_n_i           = 1'b0;
    ex_valid_i         = 1'b0;
    ex_rf_we_i         = 1'b0;
    ex_rf_waddr_i      = 5'd0;
    ex_rf_wdata_i      = 32'd0;
    ex_lsu_en_i        = 1'b0;
    ex_lsu_size_i      = 2'd0;
    ex_lsu_sign_i      = 1'b0;
    ex_lsu_offset_i    = 2'd0;
    ex_xif_en_i        = 1'b0;
    kill_wb_i          = 1'b0;
    halt_wb_i          = 1'b0;
    bus_rvalid_i       = 1'b0;
    bus_rdata_i        = 32'd0;
    bus_err_i          = 1'b0;
    xif_result_valid_i = 1'b0;
    xif_result_data_i  = 32'd0;
    xif_result_exc_i   = 1'b0;
    rd_addr_a_i        = 5'd0;
    rd_addr_b_i        = 5'd0;
    seed               = 32'hb46e;
    error_count        = 0;
    pass_count         = 0;
    fail_count         = 0;
    timed_out          = 1'b0;
    for (int i = 0; i < 32; i++) begin
      model_rf[i] = 32'd0;
    end
    // Unused entries read as end markers
    for (int i = 0; i < MAX_VECTORS; i++) begin
      vectors[i] = {KIND_END, 92'd0};
    end
    $readmemh("wb_vectors.txt", vectors);

    repeat (2) @(posedge clk);
    arst_n_i <= 1'b1;

    idx = 0;
    while (idx < MAX_VECTORS && vectors[idx][95:92] != KIND_END && !timed_out) begin
      run_test(vectors[idx], idx);
      idx++;
    end

    $display("tests %0d, passed %0d, failed %0d, mismatches %0d",
             pass_count + fail_count, pass_count, fail_count, error_count);
    if (error_count == 0 && fail_count == 0 && pass_count > 0 && !timed_out) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_wb_top_sva.sv
// Concurrent checks on the write-back end
// Completion against stall, halt write suppression, coprocessor ready,
// and the one-cycle load response capture
`timescale 1ns/100ps
`default_nettype none

module tb_wb_top_sva (
  input logic clk,
  input logic arst_n_i,
  input logic wb_valid_i,
  input logic data_stall_i,
  input logic halt_wb_i,
  input logic kill_wb_i,
  input logic rf_we_i,
  input logic xif_result_ready_i,
  input logic instr_valid_i,
  input logic xif_en_i,
  input logic bus_rvalid_i,
  input logic lsu_valid_i,
  input logic lsu_rvalid_i
);

  // A stalled load cannot complete in the same cycle
  a_valid_stall: assert property (@(posedge clk) disable iff (!arst_n_i)
    !(wb_valid_i && data_stall_i))
    else $error("wb_valid_o and data_stall_o high together");

  // Halted instruction never reaches the register file
  a_halt_no_write: assert property (@(posedge clk) disable iff (!arst_n_i)
    halt_wb_i |-> !rf_we_i)
    else $error("register write while halt_wb_i is high");

  // Result ready only for a live coprocessor instruction in write-back
  a_xif_ready: assert property (@(posedge clk) disable iff (!arst_n_i)
    xif_result_ready_i |-> (instr_valid_i && xif_en_i && !kill_wb_i && !halt_wb_i))
    else $error("xif_result_ready_o without a live coprocessor instruction");

  //////////////////////////////////////////////////////////////////////
  // Load response timing
  //////////////////////////////////////////////////////////////////////

  a_rvalid_next: assert property (@(posedge clk) disable iff (!arst_n_i)
    (bus_rvalid_i && lsu_valid_i) |=> lsu_rvalid_i)
    else $error("lsu_rvalid missing one cycle after an accepted response");

  // No rise without an accepted pulse the cycle before
  a_rvalid_rise: assert property (@(posedge clk) disable iff (!arst_n_i)
    $rose(lsu_rvalid_i) |-> $past(bus_rvalid_i && lsu_valid_i))
    else $error("lsu_rvalid rose without an accepted bus response");

endmodule

`default_nettype wire

//--- tb_clkgen.sv
// Testbench clock source
// Free-running clock with a 40 ns period, low at time zero
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
  output logic clk_o
);

  // Half period of 20 ns
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

//--- wb_top.sv
// Write-back end of the integer pipeline
// EX/WB register, load response path, write-back stage and register file
`timescale 1ns/100ps
`default_nettype none

module wb_top import wb_pkg::*, lsu_pkg::*; (
  input  logic                     clk,
  input  logic                     arst_n_i,

  // Execute side
  input  logic                     ex_valid_i,
  input  logic                     ex_rf_we_i,
  input  logic [RF_ADDR_W-1:0]     ex_rf_waddr_i,
  input  logic [XLEN-1:0]          ex_rf_wdata_i,
  input  logic                     ex_lsu_en_i,
  input  logic [LSU_SIZE_BITS-1:0] ex_lsu_size_i,
  input  logic                     ex_lsu_sign_i,
  input  logic [LSU_OFFSET_W-1:0]  ex_lsu_offset_i,
  input  logic                     ex_xif_en_i,
  output logic                     ex_ready_o,

  // Controller
  input  logic                     kill_wb_i,
  input  logic                     halt_wb_i,

  // Data bus response
  input  logic                     bus_rvalid_i,
  input  logic [XLEN-1:0]          bus_rdata_i,
  input  logic                     bus_err_i,

  // Coprocessor result
  input  logic                     xif_result_valid_i,
  input  logic [XLEN-1:0]          xif_result_data_i,
  input  logic                     xif_result_exc_i,
  output logic                     xif_result_ready_o,

  // Stage status
  output logic                     wb_valid_o,
  output logic                     data_stall_o,

  // Register read ports
  input  logic [RF_ADDR_W-1:0]     rd_addr_a_i,
  input  logic [RF_ADDR_W-1:0]     rd_addr_b_i,
  output logic [XLEN-1:0]          rd_data_a_o,
  output logic [XLEN-1:0]          rd_data_b_o
);

  // Instruction held in write-back
  logic                     wb_instr_valid;
  logic                     wb_rf_we;
  logic [RF_ADDR_W-1:0]     wb_rf_waddr;
  logic [XLEN-1:0]          wb_rf_wdata;
  logic                     wb_lsu_en;
  logic [LSU_SIZE_BITS-1:0] wb_lsu_size;
  logic                     wb_lsu_sign;
  logic [LSU_OFFSET_W-1:0]  wb_lsu_offset;
  logic                     wb_xif_en;

  // Stage handshake and load path
  logic                     wb_ready;
  logic                     lsu_valid;
  logic                     lsu_rvalid;
  logic [XLEN-1:0]          lsu_rdata;
  logic                     lsu_status;

  // Register write port
  logic                     rf_we;
  logic [RF_ADDR_W-1:0]     rf_waddr;
  logic [XLEN-1:0]          rf_wdata;

  // Execute sees the stage ready directly
  assign ex_ready_o = wb_ready;

  ex_wb_reg u_ex_wb_reg (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .ex_valid_i      (ex_valid_i),
    .ex_rf_we_i      (ex_rf_we_i),
    .ex_rf_waddr_i   (ex_rf_waddr_i),
    .ex_rf_wdata_i   (ex_rf_wdata_i),
    .ex_lsu_en_i     (ex_lsu_en_i),
    .ex_lsu_size_i   (ex_lsu_size_i),
    .ex_lsu_sign_i   (ex_lsu_sign_i),
    .ex_lsu_offset_i (ex_lsu_offset_i),
    .ex_xif_en_i     (ex_xif_en_i),
    .wb_ready_i      (wb_ready),
    .kill_wb_i       (kill_wb_i),
    .instr_valid_o   (wb_instr_valid),
    .rf_we_o         (wb_rf_we),
    .rf_waddr_o      (wb_rf_waddr),
    .rf_wdata_o      (wb_rf_wdata),
    .lsu_en_o        (wb_lsu_en),
    .lsu_size_o      (wb_lsu_size),
    .lsu_sign_o      (wb_lsu_sign),
    .lsu_offset_o    (wb_lsu_offset),
    .xif_en_o        (wb_xif_en)
  );

  load_resp u_load_resp (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .lsu_valid_i  (lsu_valid),
    .wb_ready_i   (wb_ready),
    .bus_rvalid_i (bus_rvalid_i),
    .bus_rdata_i  (bus_rdata_i),
    .bus_err_i    (bus_err_i),
    .lsu_size_i   (wb_lsu_size),
    .lsu_sign_i   (wb_lsu_sign),
    .lsu_offset_i (wb_lsu_offset),
    .lsu_rvalid_o (lsu_rvalid),
    .lsu_rdata_o  (lsu_rdata),
    .lsu_status_o (lsu_status)
  );

  wb_stage u_wb_stage (
    .instr_valid_i      (wb_instr_valid),
    .rf_we_i            (wb_rf_we),
    .rf_waddr_i         (wb_rf_waddr),
    .rf_wdata_i         (wb_rf_wdata),
    .lsu_en_i           (wb_lsu_en),
    .xif_en_i           (wb_xif_en),
    .kill_wb_i          (kill_wb_i),
    .halt_wb_i          (halt_wb_i),
    .lsu_rvalid_i       (lsu_rvalid),
    .lsu_rdata_i        (lsu_rdata),
    .lsu_status_i       (lsu_status),
    .xif_result_valid_i (xif_result_valid_i),
    .xif_result_data_i  (xif_result_data_i),
    .xif_result_exc_i   (xif_result_exc_i),
    .rf_we_o            (rf_we),
    .rf_waddr_o         (rf_waddr),
    .rf_wdata_o         (rf_wdata),
    .lsu_valid_o        (lsu_valid),
    .wb_ready_o         (wb_ready),
    .wb_valid_o         (wb_valid_o),
    .data_stall_o       (data_stall_o),
    .xif_result_ready_o (xif_result_ready_o)
  );

  regfile u_regfile (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata),
    .raddr_a_i (rd_addr_a_i),
    .raddr_b_i (rd_addr_b_i),
    .rdata_a_o (rd_data_a_o),
    .rdata_b_o (rd_data_b_o)
  );

endmodule

`default_nettype wire

//--- regfile.sv
// Integer register file
// 32 entries, one write port, two combinational read ports, x0 fixed at zero
`timescale 1ns/100ps
`default_nettype none

module regfile import wb_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n_i,

  // Write port
  input  logic                 we_i,
  input  logic [RF_ADDR_W-1:0] waddr_i,
  input  logic [XLEN-1:0]      wdata_i,

  // Read ports
  input  logic [RF_ADDR_W-1:0] raddr_a_i,
  input  logic [RF_ADDR_W-1:0] raddr_b_i,
  output logic [XLEN-1:0]      rdata_a_o,
  output logic [XLEN-1:0]      rdata_b_o
);

  logic [XLEN-1:0] regs_q [NUM_REGS];

  // Entry 0 is never written, so it stays at its reset value
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Reads see a write from the edge before
  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

`default_nettype wire

//--- wb_stage.sv
// Write-back stage
// Result select from load, coprocessor or execute, register write gating,
// and the stage valid, ready and stall outputs
`timescale 1ns/100ps
`default_nettype none

module wb_stage import wb_pkg::*, lsu_pkg::*; (
  // Instruction from the EX/WB register
  input  logic                 instr_valid_i,
  input  logic                 rf_we_i,
  input  logic [RF_ADDR_W-1:0] rf_waddr_i,
  input  logic [XLEN-1:0]      rf_wdata_i,
  input  logic                 lsu_en_i,
  input  logic                 xif_en_i,

  // Controller
  input  logic                 kill_wb_i,
  input  logic                 halt_wb_i,

  // Load path
  input  logic                 lsu_rvalid_i,
  input  logic [XLEN-1:0]      lsu_rdata_i,
  input  logic                 lsu_status_i,

  // Coprocessor result
  input  logic                 xif_result_valid_i,
  input  logic [XLEN-1:0]      xif_result_data_i,
  input  logic                 xif_result_exc_i,

  // Register file write port
  output logic                 rf_we_o,
  output logic [RF_ADDR_W-1:0] rf_waddr_o,
  output logic [XLEN-1:0]      rf_wdata_o,

  // Stage status
  output logic                 lsu_valid_o,
  output logic                 wb_ready_o,
  output logic                 wb_valid_o,
  output logic                 data_stall_o,
  output logic                 xif_result_ready_o
);

  logic instr_valid;
  logic lsu_waiting;
  logic lsu_exception;
  logic xif_waiting;
  logic xif_exception;

  // Live instruction, not killed and not halted
  assign instr_valid = instr_valid_i && !kill_wb_i && !halt_wb_i;

  // Load still without its response
  assign lsu_waiting   = instr_valid_i && lsu_en_i && !lsu_rvalid_i;
  // Faulted load, known only once the response is held
  assign lsu_exception = lsu_en_i && lsu_rvalid_i && (lsu_status_i == ACC_FAULT);

  // Coprocessor result not there yet
  assign xif_waiting   = instr_valid_i && xif_en_i && !xif_result_valid_i;
  assign xif_exception = instr_valid_i && xif_en_i && xif_result_valid_i && xif_result_exc_i;

  //////////////////////////////////////////////////////////////////////
  // Register file write
  //////////////////////////////////////////////////////////////////////

  // No write before the result is there, and none on a fault
  assign rf_we_o = rf_we_i && instr_valid && !lsu_waiting && !lsu_exception &&
                   !xif_waiting && !xif_exception;

  assign rf_waddr_o = rf_waddr_i;

  // Load data first, then coprocessor, else the execute result
  assign rf_wdata_o = lsu_en_i ? lsu_rdata_i :
                      xif_en_i ? xif_result_data_i : rf_wdata_i;

  //////////////////////////////////////////////////////////////////////
  // Stage handshake
  //////////////////////////////////////////////////////////////////////

  // Kept high during halt so a held response is not lost
  assign lsu_valid_o = instr_valid_i && lsu_en_i;

  // Kill always frees the stage
  assign wb_ready_o = kill_wb_i || (!lsu_waiting && !xif_waiting && !halt_wb_i);

  // Faulted loads and coprocessor exceptions still complete
  assign wb_valid_o = ((!lsu_en_i && !xif_waiting) || (lsu_en_i && lsu_rvalid_i)) &&
                      instr_valid;

  assign data_stall_o = lsu_en_i && !lsu_rvalid_i && instr_valid;

  // Result taken only by a live offloaded instruction
  assign xif_result_ready_o = instr_valid && xif_en_i;

endmodule

`default_nettype wire

//--- load_resp.sv
// Load response path
// Captures one data bus response, holds it until write-back advances,
// and aligns and extends the selected byte or halfword
`timescale 1ns/100ps
`default_nettype none

module load_resp import wb_pkg::*, lsu_pkg::*; (
  input  logic                     clk,
  input  logic                     arst_n_i,

  // From the write-back stage
  input  logic                     lsu_valid_i,
  input  logic                     wb_ready_i,

  // Data bus response
  input  logic                     bus_rvalid_i,
  input  logic [XLEN-1:0]          bus_rdata_i,
  input  logic                     bus_err_i,

  // Load attributes of the instruction in write-back
  input  logic [LSU_SIZE_BITS-1:0] lsu_size_i,
  input  logic                     lsu_sign_i,
  input  logic [LSU_OFFSET_W-1:0]  lsu_offset_i,

  // Held, aligned response
  output logic                     lsu_rvalid_o,
  output logic [XLEN-1:0]          lsu_rdata_o,
  output logic                     lsu_status_o
);

  logic            resp_accept;
  logic [XLEN-1:0] rdata_q;
  lsu_word_u       rword;

  // Bus pulses outside a live load are ignored
  assign resp_accept = bus_rvalid_i && lsu_valid_i;

  //////////////////////////////////////////////////////////////////////
  // Response hold
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lsu_rvalid_o <= 1'b0;
    end else if (resp_accept) begin
      lsu_rvalid_o <= 1'b1;
    end else if (wb_ready_i) begin
      // Load has left write-back
      lsu_rvalid_o <= 1'b0;
    end
  end

  // Word and status, qualified by lsu_rvalid_o
  always_ff @(posedge clk) begin
    if (resp_accept) begin
      rdata_q      <= bus_rdata_i;
      lsu_status_o <= bus_err_i ? ACC_FAULT : ACC_OK;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Alignment and extension
  //////////////////////////////////////////////////////////////////////

  assign rword = rdata_q;

  always_comb begin
    case (lsu_size_i)
      LSU_SIZE_B: begin
        // Byte lane picked by the full offset
        lsu_rdata_o = {{24{lsu_sign_i && rword.b[lsu_offset_i][7]}},
                       rword.b[lsu_offset_i]};
      end
      LSU_SIZE_H: begin
        // Upper offset bit picks the halfword
        lsu_rdata_o = {{16{lsu_sign_i && rword.h[lsu_offset_i[1]][15]}},
                       rword.h[lsu_offset_i[1]]};
      end
      // Word loads pass the held word through
      default:    lsu_rdata_o = rdata_q;
    endcase
  end

endmodule

`default_nettype wire

//--- ex_wb_reg.sv
// EX/WB pipeline register
// Holds one instruction for write-back, with back-pressure and kill
`timescale 1ns/100ps
`default_nettype none

module ex_wb_reg import wb_pkg::*, lsu_pkg::*; (
  input  logic                     clk,
  input  logic                     arst_n_i,

  // Execute side
  input  logic                     ex_valid_i,
  input  logic                     ex_rf_we_i,
  input  logic [RF_ADDR_W-1:0]     ex_rf_waddr_i,
  input  logic [XLEN-1:0]          ex_rf_wdata_i,
  input  logic                     ex_lsu_en_i,
  input  logic [LSU_SIZE_BITS-1:0] ex_lsu_size_i,
  input  logic                     ex_lsu_sign_i,
  input  logic [LSU_OFFSET_W-1:0]  ex_lsu_offset_i,
  input  logic                     ex_xif_en_i,

  // Stage control
  input  logic                     wb_ready_i,
  input  logic                     kill_wb_i,

  // Instruction in write-back
  output logic                     instr_valid_o,
  output logic                     rf_we_o,
  output logic [RF_ADDR_W-1:0]     rf_waddr_o,
  output logic [XLEN-1:0]          rf_wdata_o,
  output logic                     lsu_en_o,
  output logic [LSU_SIZE_BITS-1:0] lsu_size_o,
  output logic                     lsu_sign_o,
  output logic [LSU_OFFSET_W-1:0]  lsu_offset_o,
  output logic                     xif_en_o
);

  //////////////////////////////////////////////////////////////////////
  // Valid bit
  //////////////////////////////////////////////////////////////////////

  // New instruction wins over a kill in the same cycle
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      instr_valid_o <= 1'b0;
    end else if (wb_ready_i && ex_valid_i) begin
      instr_valid_o <= 1'b1;
    end else if (wb_ready_i || kill_wb_i) begin
      // Stage drained or instruction dropped
      instr_valid_o <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Instruction fields
  //////////////////////////////////////////////////////////////////////

  // Fields only matter while the valid bit is set
  always_ff @(posedge clk) begin
    if (wb_ready_i) begin
      rf_we_o      <= ex_rf_we_i;
      rf_waddr_o   <= ex_rf_waddr_i;
      rf_wdata_o   <= ex_rf_wdata_i;
      lsu_en_o     <= ex_lsu_en_i;
      lsu_size_o   <= ex_lsu_size_i;
      lsu_sign_o   <= ex_lsu_sign_i;
      lsu_offset_o <= ex_lsu_offset_i;
      xif_en_o     <= ex_xif_en_i;
    end
  end

endmodule

`default_nettype wire

//--- lsu_pkg.sv
// Load size codes and access status codes
// Load word union with a byte view and a halfword view
`default_nettype none

package lsu_pkg;

  // Width of the size code and of the byte offset within a word
  localparam int unsigned LSU_SIZE_BITS = 2;
  localparam int unsigned LSU_OFFSET_W  = 2;

  // Load size codes
  localparam logic [LSU_SIZE_BITS-1:0] LSU_SIZE_B = 2'b00;
  localparam logic [LSU_SIZE_BITS-1:0] LSU_SIZE_H = 2'b01;
  localparam logic [LSU_SIZE_BITS-1:0] LSU_SIZE_W = 2'b10;

  // Access status that travels with every bus response
  localparam logic ACC_OK    = 1'b0;
  localparam logic ACC_FAULT = 1'b1;

  //////////////////////////////////////////////////////////////////////
  // Load word, seen either as bytes or as halfwords
  //////////////////////////////////////////////////////////////////////

  // Byte 0 and halfword 0 sit in the low bits (little endian)
  typedef union packed {
    logic [3:0][7:0]  b;
    logic [1:0][15:0] h;
  } lsu_word_u;

endpackage

`default_nettype wire

//--- wb_pkg.sv
// Register file and pipeline constants
// Shared by the EX/WB register, write-back stage, register file and top
`default_nettype none

package wb_pkg;

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  // Integer register width
  localparam int unsigned XLEN = 32;

  //////////////////////////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////////////////////////

  // Enough address bits for x0 to x31
  localparam int unsigned RF_ADDR_W = 5;

  // Entry count, x0 included
  localparam int unsigned NUM_REGS = 32;

endpackage

`default_nettype wire
